// ==== hw/video_pkg.sv ====
package video_pkg;

    localparam int CHANNEL_W = 8;

    // one color component
    typedef logic [CHANNEL_W-1:0] channel_t;

    // red sits in the top byte, blue in the low byte
    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
    } pixel_t;

    localparam channel_t CHANNEL_MAX = 8'd255;  // saturation level per channel

    // frame timing generator
    typedef enum logic [1:0] {
        ST_IDLE  = 2'b00,   // waiting for start
        ST_VSYNC = 2'b01,   // frame sync pulse
        ST_HSYNC = 2'b10,   // blank gap ahead of a line
        ST_DATA  = 2'b11    // one pixel pair read per cycle
    } timing_state_e;

endpackage

// ==== hw/op_pkg.sv ====
package op_pkg;

    localparam int OP_W = 3;

    // point operations, set through CTRL[6:4]
    typedef enum logic [OP_W-1:0] {
        OP_PASS       = 3'd0,
        OP_BRIGHT_ADD = 3'd1,   // saturates at 255
        OP_BRIGHT_SUB = 3'd2,   // clamps at 0
        OP_INVERT     = 3'd3,
        OP_GRAY       = 3'd4,   // floor of the channel average
        OP_THRESHOLD  = 3'd5    // strictly greater than threshold
    } op_e;

    // APB byte offsets
    typedef enum logic [7:0] {
        REG_CTRL     = 8'h00,
        REG_VALUE    = 8'h04,
        REG_THRESH   = 8'h08,
        REG_STATUS   = 8'h0C,   // read only
        REG_PIX_ADDR = 8'h10,
        REG_PIX_DATA = 8'h14    // write bumps the pixel index
    } reg_addr_e;

    localparam int CTRL_START_BIT = 0;  // write pulse, reads 0
    localparam int CTRL_OP_LSB    = 4;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;

endpackage

// ==== hw/frame_store.sv ====
`timescale 1ns/10ps

module frame_store #(
    parameter int IMG_WIDTH  = 8,
    parameter int IMG_HEIGHT = 4,
    localparam int DEPTH     = IMG_WIDTH * IMG_HEIGHT,
    localparam int PIX_AW    = $clog2(DEPTH),
    localparam int PAIR_AW   = PIX_AW - 1
) (
    input  logic               HCLK,
    input  logic               pix_we,
    input  logic [PIX_AW-1:0]  pix_index,
    input  video_pkg::pixel_t  pix_data,
    input  logic               rd_en,
    input  logic [PAIR_AW-1:0] pair_index,
    output video_pkg::pixel_t  pix_even,
    output video_pkg::pixel_t  pix_odd
);
    import video_pkg::*;

    pixel_t            mem [DEPTH];  // row major, left pixel first
    logic              wr_ok;
    logic [PIX_AW-1:0] even_addr;
    logic [PIX_AW-1:0] odd_addr;

    // indices past the frame are dropped
    assign wr_ok = pix_we && (pix_index < PIX_AW'(DEPTH - 1) || pix_index == PIX_AW'(DEPTH - 1));

    assign even_addr = {pair_index, 1'b0};
    assign odd_addr  = {pair_index, 1'b1};

    always_ff @(posedge HCLK) begin
        if (wr_ok) begin
            mem[pix_index] <= pix_data;
        end
    end

    // one cycle read, outputs hold between reads
    always_ff @(posedge HCLK) begin
        if (rd_en) begin
            pix_even <= mem[even_addr];
            pix_odd  <= mem[odd_addr];
        end
    end

endmodule

// ==== hw/sync_timing.sv ====
`timescale 1ns/10ps

module sync_timing #(
    parameter int IMG_WIDTH    = 8,
    parameter int IMG_HEIGHT   = 4,
    parameter int VSYNC_CYCLES = 6,
    parameter int HSYNC_GAP    = 3,
    localparam int PAIR_AW     = $clog2(IMG_WIDTH * IMG_HEIGHT / 2)
) (
    input  logic               HCLK,
    input  logic               HRESETn,
    input  logic               start,
    output logic               VSYNC,
    output logic               HSYNC,
    output logic               busy,
    output logic               done,
    output logic               rd_en,
    output logic [PAIR_AW-1:0] pair_index
);
    import video_pkg::*;

    localparam int PAIRS_PER_ROW = IMG_WIDTH / 2;
    localparam int COL_W   = (PAIRS_PER_ROW > 1) ? $clog2(PAIRS_PER_ROW) : 1;
    localparam int ROW_W   = (IMG_HEIGHT > 1) ? $clog2(IMG_HEIGHT) : 1;
    localparam int DLY_MAX = (VSYNC_CYCLES > HSYNC_GAP) ? VSYNC_CYCLES : HSYNC_GAP;
    localparam int DLY_W   = $clog2(DLY_MAX + 1);

    timing_state_e    state;
    timing_state_e    state_nxt;
    logic [DLY_W-1:0] dly_cnt;
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic             line_end;
    logic             frame_end;
    logic             hsync_q;
    logic             last_q;

    assign line_end  = (col == COL_W'(PAIRS_PER_ROW - 1));
    assign frame_end = (row == ROW_W'(IMG_HEIGHT - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_nxt = ST_VSYNC;
                end
            end
            ST_VSYNC: begin
                if (dly_cnt == DLY_W'(VSYNC_CYCLES - 1)) begin
                    state_nxt = ST_HSYNC;
                end
            end
            ST_HSYNC: begin
                if (dly_cnt == DLY_W'(HSYNC_GAP - 1)) begin
                    state_nxt = ST_DATA;
                end
            end
            ST_DATA: begin
                if (line_end) begin
                    state_nxt = frame_end ? ST_IDLE : ST_HSYNC;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state   <= ST_IDLE;
            dly_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state_nxt != state) begin
                dly_cnt <= '0;  // restart on every state change
            end else if (state == ST_VSYNC || state == ST_HSYNC) begin
                dly_cnt <= dly_cnt + 1'b1;
            end
        end
    end

    // one pair per data cycle, rows top to bottom
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            col <= '0;
            row <= '0;
        end else if (state == ST_DATA) begin
            if (line_end) begin
                col <= '0;
                row <= frame_end ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            hsync_q <= 1'b0;
            last_q  <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
        end else begin
            hsync_q <= (state == ST_DATA);  // lines up with the store output
            last_q  <= (state == ST_DATA) && line_end && frame_end;
            if (start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (last_q) begin  // cycle after the last pair is out
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    assign VSYNC      = (state == ST_VSYNC);
    assign HSYNC      = hsync_q;
    assign rd_en      = (state == ST_DATA);
    assign pair_index = PAIR_AW'(row * PAIRS_PER_ROW + col);

endmodule

// ==== hw/pixel_op.sv ====
`timescale 1ns/10ps

module pixel_op (
    input  op_pkg::op_e         op,
    input  video_pkg::channel_t value,
    input  video_pkg::channel_t threshold,
    input  logic                active,
    input  video_pkg::pixel_t   pix_in,
    output video_pkg::pixel_t   pix_out
);
    import video_pkg::*;
    import op_pkg::*;

    logic [9:0] sum3;
    channel_t   gray;
    pixel_t     result;

    function automatic channel_t add_sat(channel_t a, channel_t b);
        logic [8:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[8] ? CHANNEL_MAX : s[7:0];
    endfunction

    function automatic channel_t sub_clamp(channel_t a, channel_t b);
        return (a >= b) ? channel_t'(a - b) : '0;
    endfunction

    assign sum3 = {2'b00, pix_in.r} + {2'b00, pix_in.g} + {2'b00, pix_in.b};
    assign gray = channel_t'(sum3 / 10'd3);  // 765/3 fits in a byte

    always_comb begin
        result = pix_in;
        case (op)
            OP_BRIGHT_ADD: begin
                result.r = add_sat(pix_in.r, value);
                result.g = add_sat(pix_in.g, value);
                result.b = add_sat(pix_in.b, value);
            end
            OP_BRIGHT_SUB: begin
                result.r = sub_clamp(pix_in.r, value);
                result.g = sub_clamp(pix_in.g, value);
                result.b = sub_clamp(pix_in.b, value);
            end
            OP_INVERT: begin
                result.r = CHANNEL_MAX - pix_in.r;
                result.g = CHANNEL_MAX - pix_in.g;
                result.b = CHANNEL_MAX - pix_in.b;
            end
            OP_GRAY: begin
                result = '{gray, gray, gray};
            end
            OP_THRESHOLD: begin
                result = (gray > threshold) ? '{CHANNEL_MAX, CHANNEL_MAX, CHANNEL_MAX} : '0;
            end
            default: begin  // pass and unused codes
                result = pix_in;
            end
        endcase
    end

    assign pix_out = active ? result : '0;  // blank outside the line

endmodule

// ==== hw/apb_regs.sv ====
`timescale 1ns/10ps

module apb_regs #(
    parameter int IMG_WIDTH  = 8,
    parameter int IMG_HEIGHT = 4,
    localparam int PIX_AW    = $clog2(IMG_WIDTH * IMG_HEIGHT)
) (
    input  logic                HCLK,
    input  logic                HRESETn,
    input  logic [31:0]         PADDR,
    input  logic                PSEL,
    input  logic                PENABLE,
    input  logic                PWRITE,
    input  logic [31:0]         PWDATA,
    output logic [31:0]         PRDATA,
    input  logic                busy,
    input  logic                done,
    output logic                start,
    output op_pkg::op_e         op,
    output video_pkg::channel_t value,
    output video_pkg::channel_t threshold,
    output logic                pix_we,
    output logic [PIX_AW-1:0]   pix_index,
    output video_pkg::pixel_t   pix_data
);
    import op_pkg::*;

    reg_addr_e         addr;
    logic              in_window;
    logic              wr_en;
    logic              rd_en;
    logic [PIX_AW-1:0] index_q;

    assign addr      = reg_addr_e'(PADDR[7:0]);
    assign in_window = (PADDR[31:8] == '0);  // map occupies the low 256 bytes

    // writes land on the edge closing the access phase, frozen while a frame runs
    assign wr_en = PSEL && PENABLE && PWRITE && !busy && in_window;
    assign rd_en = PSEL && !PWRITE && in_window;

    // pixel load goes straight into the store on the same edge
    assign pix_we    = wr_en && (addr == REG_PIX_DATA);
    assign pix_index = index_q;
    assign pix_data  = PWDATA[23:0];

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            start     <= 1'b0;
            op        <= OP_PASS;
            value     <= '0;
            threshold <= '0;
            index_q   <= '0;
        end else begin
            start <= wr_en && (addr == REG_CTRL) && PWDATA[CTRL_START_BIT];  // one cycle
            if (wr_en) begin
                case (addr)
                    REG_CTRL: begin
                        op <= op_e'(PWDATA[CTRL_OP_LSB +: OP_W]);
                    end
                    REG_VALUE: begin
                        value <= PWDATA[7:0];
                    end
                    REG_THRESH: begin
                        threshold <= PWDATA[7:0];
                    end
                    REG_PIX_ADDR: begin
                        index_q <= PWDATA[PIX_AW-1:0];
                    end
                    REG_PIX_DATA: begin
                        index_q <= index_q + 1'b1;  // auto increment
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // read data valid through setup and access
    always_comb begin
        PRDATA = '0;
        if (rd_en) begin
            case (addr)
                REG_CTRL: begin
                    PRDATA[CTRL_OP_LSB +: OP_W] = op;  // start bit stays 0
                end
                REG_VALUE: begin
                    PRDATA[7:0] = value;
                end
                REG_THRESH: begin
                    PRDATA[7:0] = threshold;
                end
                REG_STATUS: begin
                    PRDATA[STAT_BUSY_BIT] = busy;
                    PRDATA[STAT_DONE_BIT] = done;
                end
                REG_PIX_ADDR: begin
                    PRDATA[PIX_AW-1:0] = index_q;
                end
                default: begin  // PIX_DATA is write only
                end
            endcase
        end
    end

endmodule

// ==== hw/image_proc_top.sv ====
`timescale 1ns/10ps

module image_proc_top #(
    parameter int IMG_WIDTH    = 8,
    parameter int IMG_HEIGHT   = 4,
    parameter int VSYNC_CYCLES = 6,
    parameter int HSYNC_GAP    = 3
) (
    input  logic                HCLK,
    input  logic                HRESETn,
    input  logic [31:0]         PADDR,
    input  logic                PSEL,
    input  logic                PENABLE,
    input  logic                PWRITE,
    input  logic [31:0]         PWDATA,
    output logic [31:0]         PRDATA,
    output logic                VSYNC,
    output logic                HSYNC,
    output video_pkg::channel_t DATA_R0,
    output video_pkg::channel_t DATA_G0,
    output video_pkg::channel_t DATA_B0,
    output video_pkg::channel_t DATA_R1,
    output video_pkg::channel_t DATA_G1,
    output video_pkg::channel_t DATA_B1
);
    import video_pkg::*;
    import op_pkg::*;

    localparam int PIX_AW  = $clog2(IMG_WIDTH * IMG_HEIGHT);
    localparam int PAIR_AW = $clog2(IMG_WIDTH * IMG_HEIGHT / 2);

    logic               busy;
    logic               done;
    logic               start;
    op_e                op;
    channel_t           value;
    channel_t           threshold;
    logic               pix_we;
    logic [PIX_AW-1:0]  pix_index;
    pixel_t             pix_data;
    logic               rd_en;
    logic [PAIR_AW-1:0] pair_index;
    pixel_t             pix_even;
    pixel_t             pix_odd;
    pixel_t             out_even;
    pixel_t             out_odd;

    apb_regs #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) u_regs (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .PADDR     (PADDR),
        .PSEL      (PSEL),
        .PENABLE   (PENABLE),
        .PWRITE    (PWRITE),
        .PWDATA    (PWDATA),
        .PRDATA    (PRDATA),
        .busy      (busy),
        .done      (done),
        .start     (start),
        .op        (op),
        .value     (value),
        .threshold (threshold),
        .pix_we    (pix_we),
        .pix_index (pix_index),
        .pix_data  (pix_data)
    );

    frame_store #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) u_store (
        .HCLK       (HCLK),
        .pix_we     (pix_we),
        .pix_index  (pix_index),
        .pix_data   (pix_data),
        .rd_en      (rd_en),
        .pair_index (pair_index),
        .pix_even   (pix_even),
        .pix_odd    (pix_odd)
    );

    sync_timing #(
        .IMG_WIDTH    (IMG_WIDTH),
        .IMG_HEIGHT   (IMG_HEIGHT),
        .VSYNC_CYCLES (VSYNC_CYCLES),
        .HSYNC_GAP    (HSYNC_GAP)
    ) u_timing (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .start      (start),
        .VSYNC      (VSYNC),
        .HSYNC      (HSYNC),
        .busy       (busy),
        .done       (done),
        .rd_en      (rd_en),
        .pair_index (pair_index)
    );

    // HSYNC doubles as the data valid for both lanes
    pixel_op u_op_even (
        .op        (op),
        .value     (value),
        .threshold (threshold),
        .active    (HSYNC),
        .pix_in    (pix_even),
        .pix_out   (out_even)
    );

    pixel_op u_op_odd (
        .op        (op),
        .value     (value),
        .threshold (threshold),
        .active    (HSYNC),
        .pix_in    (pix_odd),
        .pix_out   (out_odd)
    );

    assign DATA_R0 = out_even.r;
    assign DATA_G0 = out_even.g;
    assign DATA_B0 = out_even.b;
    assign DATA_R1 = out_odd.r;
    assign DATA_G1 = out_odd.g;
    assign DATA_B1 = out_odd.b;

endmodule

// ==== dv/image_proc_chk.sv ====
`timescale 1ns/10ps

module image_proc_chk (
    input logic HCLK,
    input logic HRESETn,
    input logic start,
    input logic VSYNC,
    input logic HSYNC,
    input logic busy,
    input logic done
);

    a_sync_excl: assert property (@(posedge HCLK) disable iff (!HRESETn) !(VSYNC && HSYNC))
        else $error("VSYNC and HSYNC high in the same cycle");

    // line data only inside a running frame
    a_hsync_busy: assert property (@(posedge HCLK) disable iff (!HRESETn) HSYNC |-> busy)
        else $error("HSYNC high while not busy");

    a_done_busy: assert property (@(posedge HCLK) disable iff (!HRESETn) !(done && busy))
        else $error("done and busy high together");

    // start with no frame running
    a_start_vsync: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (start && !busy) |=> VSYNC)
        else $error("no VSYNC on the cycle after start");

endmodule

bind sync_timing image_proc_chk u_chk (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .start   (start),
    .VSYNC   (VSYNC),
    .HSYNC   (HSYNC),
    .busy    (busy),
    .done    (done)
);

// ==== dv/tb_image_proc.sv ====
`timescale 1ns/10ps

module tb_image_proc;
    import video_pkg::*;
    import op_pkg::*;

    localparam int IMG_WIDTH    = 8;
    localparam int IMG_HEIGHT   = 4;
    localparam int VSYNC_CYCLES = 6;
    localparam int HSYNC_GAP    = 3;
    localparam int NPIX         = IMG_WIDTH * IMG_HEIGHT;
    localparam int NPAIRS       = NPIX / 2;
    localparam int FRAME_LIMIT  = 400;  // cycles per frame
    localparam int DONE_POLLS   = 20;

    logic        HCLK;
    logic        HRESETn;
    logic [31:0] PADDR;
    logic        PSEL;
    logic        PENABLE;
    logic        PWRITE;
    logic [31:0] PWDATA;
    logic [31:0] PRDATA;
    logic        VSYNC;
    logic        HSYNC;
    channel_t    DATA_R0;
    channel_t    DATA_G0;
    channel_t    DATA_B0;
    channel_t    DATA_R1;
    channel_t    DATA_G1;
    channel_t    DATA_B1;

    pixel_t      img [NPIX];  // frame as loaded into the DUT
    logic [31:0] pat [64];
    integer      seed;
    int          errors;
    int          test_no;
    int          tests_pass;
    int          tests_fail;
    int          err_at_begin;
    string       test_name;
    bit          timed_out;

    image_proc_top #(
        .IMG_WIDTH    (IMG_WIDTH),
        .IMG_HEIGHT   (IMG_HEIGHT),
        .VSYNC_CYCLES (VSYNC_CYCLES),
        .HSYNC_GAP    (HSYNC_GAP)
    ) DUT (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .PADDR   (PADDR),
        .PSEL    (PSEL),
        .PENABLE (PENABLE),
        .PWRITE  (PWRITE),
        .PWDATA  (PWDATA),
        .PRDATA  (PRDATA),
        .VSYNC   (VSYNC),
        .HSYNC   (HSYNC),
        .DATA_R0 (DATA_R0),
        .DATA_G0 (DATA_G0),
        .DATA_B0 (DATA_B0),
        .DATA_R1 (DATA_R1),
        .DATA_G1 (DATA_G1),
        .DATA_B1 (DATA_B1)
    );

    initial begin
        HCLK = 1'b0;
        forever #10 HCLK = ~HCLK;
    end

    function automatic channel_t clip(int x);
        if (x > 255) begin
            return 8'd255;
        end
        if (x < 0) begin
            return 8'd0;
        end
        return channel_t'(x);
    endfunction

    // point operation rules, per channel
    function automatic pixel_t expect_pixel(op_e op, channel_t v, channel_t t, pixel_t p);
        int gray;
        gray = (int'(p.r) + int'(p.g) + int'(p.b)) / 3;
        case (op)
            OP_BRIGHT_ADD: return '{clip(int'(p.r) + int'(v)), clip(int'(p.g) + int'(v)),
                                    clip(int'(p.b) + int'(v))};
            OP_BRIGHT_SUB: return '{clip(int'(p.r) - int'(v)), clip(int'(p.g) - int'(v)),
                                    clip(int'(p.b) - int'(v))};
            OP_INVERT:     return '{clip(255 - int'(p.r)), clip(255 - int'(p.g)),
                                    clip(255 - int'(p.b))};
            OP_GRAY:       return '{clip(gray), clip(gray), clip(gray)};
            OP_THRESHOLD:  return (gray > int'(t)) ? '{8'd255, 8'd255, 8'd255} : '0;
            default:       return p;
        endcase
    endfunction

    function automatic logic [31:0] ctrl_word(op_e op, logic go);
        return {25'd0, op, 3'd0, go};  // op in 6:4, start in bit 0
    endfunction

    task automatic check_pixel(input string what, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %06h expected %06h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_op(input string what, input op_e got, input op_e exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_no++;
        test_name    = name;
        err_at_begin = errors;
    endtask

    task automatic end_test();
        if (errors == err_at_begin) begin
            tests_pass++;
            $display("test %0d %s: ok", test_no, test_name);
        end else begin
            tests_fail++;
            $display("test %0d %s: FAILED with %0d errors", test_no, test_name,
                     errors - err_at_begin);
        end
    endtask

    task automatic apply_reset();
        repeat (8) @(posedge HCLK);
        HRESETn <= 1'b1;
        @(posedge HCLK);
    endtask

    task automatic apb_write(input reg_addr_e addr, input logic [31:0] data);
        @(posedge HCLK);
        PADDR   <= {24'd0, addr};
        PWRITE  <= 1'b1;
        PWDATA  <= data;
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        @(posedge HCLK);
        PENABLE <= 1'b1;
        @(posedge HCLK);  // write lands on this edge
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
    endtask

    task automatic apb_read(input reg_addr_e addr, output logic [31:0] data);
        @(posedge HCLK);
        PADDR   <= {24'd0, addr};
        PWRITE  <= 1'b0;
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        @(posedge HCLK);
        PENABLE <= 1'b1;
        @(negedge HCLK);  // mid access phase
        data = PRDATA;
        @(posedge HCLK);
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
    endtask

    task automatic load_frame();
        apb_write(REG_PIX_ADDR, 32'd0);
        for (int i = 0; i < NPIX; i++) begin
            apb_write(REG_PIX_DATA, {8'd0, img[i]});
        end
    endtask

    // samples outputs at the falling edge, checks data and sync shape together
    task automatic capture_frame(input op_e op, input channel_t v, input channel_t t);
        int     cyc;
        int     pairs;
        int     vs_len;
        int     run;
        int     gap;
        int     lines;
        logic   hs_q;
        logic   frame_over;
        pixel_t got0;
        pixel_t got1;
        cyc        = 0;
        pairs      = 0;
        vs_len     = 0;
        run        = 0;
        gap        = 0;
        lines      = 0;
        hs_q       = 1'b0;
        frame_over = 1'b0;
        while (!frame_over) begin
            @(negedge HCLK);
            cyc++;
            if (cyc > FRAME_LIMIT) begin
                $display("Timeout at %0t: frame from the DUT never completed", $time);
                timed_out = 1'b1;
                errors++;
                return;
            end
            got0 = '{DATA_R0, DATA_G0, DATA_B0};
            got1 = '{DATA_R1, DATA_G1, DATA_B1};
            if (VSYNC) begin
                vs_len++;
            end
            if (HSYNC) begin
                if (!hs_q && lines > 0) begin
                    check_word("line gap", gap, HSYNC_GAP);
                end
                if (pairs < NPAIRS) begin
                    check_pixel($sformatf("pair %0d even", pairs), got0,
                                expect_pixel(op, v, t, img[2 * pairs]));
                    check_pixel($sformatf("pair %0d odd", pairs), got1,
                                expect_pixel(op, v, t, img[2 * pairs + 1]));
                end
                pairs++;
                run++;
            end else begin
                check_pixel("blank even lane", got0, '0);
                check_pixel("blank odd lane", got1, '0);
                if (hs_q) begin  // end of a line
                    check_word("line length", run, IMG_WIDTH / 2);
                    lines++;
                    run = 0;
                    gap = 0;
                end
                if (lines > 0) begin
                    gap++;
                end
                if (pairs >= NPAIRS) begin
                    frame_over = 1'b1;
                end
            end
            hs_q = HSYNC;
        end
        check_word("vsync length", vs_len, VSYNC_CYCLES);
        check_word("line count", lines, IMG_HEIGHT);
        check_word("pair count", pairs, NPAIRS);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[STAT_DONE_BIT] && polls < DONE_POLLS) begin
            apb_read(REG_STATUS, st);
            polls++;
        end
        if (!st[STAT_DONE_BIT]) begin
            $display("Timeout at %0t: done never showed up in STATUS", $time);
            timed_out = 1'b1;
            errors++;
        end else begin
            check_word("status after frame", st, 32'd1 << STAT_DONE_BIT);
        end
    endtask

    task automatic run_frame(input op_e op, input channel_t v, input channel_t t);
        logic [31:0] rd;
        apb_write(REG_CTRL, ctrl_word(op, 1'b1));
        capture_frame(op, v, t);
        if (!timed_out) begin
            wait_done();
        end
        if (!timed_out) begin
            apb_read(REG_CTRL, rd);
            check_op("ctrl op readback", op_e'(rd[CTRL_OP_LSB +: OP_W]), op);
            check_word("ctrl start bit", 32'(rd[CTRL_START_BIT]), 32'd0);
        end
    endtask

    task automatic run_all();
        logic [31:0] rd;
        logic [31:0] rnd;
        int          base;
        int          ncase;
        op_e         op;
        channel_t    v;
        channel_t    t;
        begin_test("register readback");
        apb_read(REG_STATUS, rd);
        check_word("status after reset", rd, 32'd0);
        apb_write(REG_CTRL, ctrl_word(OP_THRESHOLD, 1'b0));
        apb_read(REG_CTRL, rd);
        check_op("ctrl op", op_e'(rd[CTRL_OP_LSB +: OP_W]), OP_THRESHOLD);
        check_word("ctrl word", rd, 32'h50);
        apb_write(REG_VALUE, 32'ha5);
        apb_read(REG_VALUE, rd);
        check_word("value", rd, 32'ha5);
        apb_write(REG_THRESH, 32'h3c);
        apb_read(REG_THRESH, rd);
        check_word("threshold", rd, 32'h3c);
        end_test();

        for (int i = 0; i < NPIX; i++) begin
            img[i] = pat[i][23:0];
        end
        load_frame();
        ncase = int'(pat[NPIX]);
        for (int i = 0; i < ncase && !timed_out; i++) begin
            base = NPIX + 1 + 3 * i;
            op   = op_e'(pat[base][2:0]);
            v    = pat[base + 1][7:0];
            t    = pat[base + 2][7:0];
            begin_test($sformatf("pattern %s value %02h thresh %02h", op.name(), v, t));
            apb_write(REG_VALUE, {24'd0, v});
            apb_write(REG_THRESH, {24'd0, t});
            run_frame(op, v, t);
            end_test();
        end

        if (!timed_out) begin
            begin_test("busy gating");
            apb_write(REG_VALUE, 32'h10);
            apb_write(REG_CTRL, ctrl_word(OP_BRIGHT_ADD, 1'b1));
            apb_write(REG_VALUE, 32'h70);  // arrives mid frame
            wait_done();
            apb_read(REG_VALUE, rd);
            check_word("value kept while busy", rd, 32'h10);
            if (!timed_out) begin
                run_frame(OP_BRIGHT_ADD, 8'h10, 8'h00);
            end
            end_test();
        end

        if (!timed_out) begin
            begin_test("random frame pass");
            seed = 32'hbb1e;
            for (int i = 0; i < NPIX; i++) begin
                rnd    = $random(seed);
                img[i] = rnd[23:0];
            end
            load_frame();
            run_frame(OP_PASS, 8'h00, 8'h00);
            end_test();
        end
    endtask

    initial begin
        HRESETn    = 1'b0;
        PADDR      = '0;
        PSEL       = 1'b0;
        PENABLE    = 1'b0;
        PWRITE     = 1'b0;
        PWDATA     = '0;
        errors     = 0;
        test_no    = 0;
        tests_pass = 0;
        tests_fail = 0;
        timed_out  = 1'b0;
        $readmemh("dv/op_patterns.txt", pat);
        apply_reset();
        run_all();
        $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
                 test_no, tests_pass, tests_fail, errors);
        if (errors == 0 && tests_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== dv/op_patterns.txt ====
// 32 pixels as RRGGBB hex, row major, four per line
// then the case count, then one case per line as: opcode value threshold
ff0000 00ff00 0000ff ffffff
000000 808080 c8c8c8 102030
fa0a7f 3c3c3c 7f8081 01fe80
818080 0f0f0f f0f0f0 aa5511
123456 654321 abcdef fedcba
404040 3f3f3f c0c0c0 bfbfbf
7f7f7f 808181 050a0f ff80ff
e0e0e0 202020 99ccff 336699
// number of cases
6
1 40 00
2 40 00
3 00 00
4 00 00
5 00 80
5 00 3f

// ==== filelist.f ====
hw/video_pkg.sv
hw/op_pkg.sv
hw/frame_store.sv
hw/sync_timing.sv
hw/pixel_op.sv
hw/apb_regs.sv
hw/image_proc_top.sv
dv/image_proc_chk.sv
dv/tb_image_proc.sv

// ==== run.sh ====
#!/bin/sh
# build the image processor testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_image_proc -f filelist.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^Everything OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
